// File: hw/sp_config.svh
`ifndef SP_CONFIG_SVH
`define SP_CONFIG_SVH

// depth of the local word memory in 32-bit words.
`define SP_LOCAL_MEM_WORDS 1024

// top address byte that selects the external byte bus window.
`define SP_EXT_REGION 8'h80

// width of the byte address driven on the external bus.
`define SP_EXT_ADDR_WIDTH 24

`endif

// File: hw/sp_pkg.sv
`include "sp_config.svh"

package sp_pkg;

   typedef logic [31:0] sp_word_t;   // data word on the core side.
   typedef logic [31:0] sp_addr_t;   // byte address from the core.
   typedef logic [3:0]  sp_sel_t;    // bit 3 selects the most significant byte.
   typedef logic [7:0]  sp_byte_t;   // data on the external byte bus.

   typedef logic [`SP_EXT_ADDR_WIDTH-1:0] sp_ext_addr_t;

   // the bridge runs its beats in bridge_beat and acknowledges in bridge_done.
   typedef enum logic [1:0] {
      bridge_idle,
      bridge_beat,
      bridge_done
   } bridge_state_t;

endpackage

// File: hw/sp_local_mem.sv
`timescale 1ns/1ps

`include "sp_config.svh"

module sp_local_mem #(
   parameter int depth_words = `SP_LOCAL_MEM_WORDS
) (
   input  logic             clk,
   input  logic             rst_i,
   input  sp_pkg::sp_addr_t d_adr_i,
   input  sp_pkg::sp_word_t d_dat_i,
   input  sp_pkg::sp_sel_t  d_sel_i,
   input  logic             d_we_i,
   input  logic             d_stb_i,
   output sp_pkg::sp_word_t d_dat_o,
   output logic             d_ack_o,
   input  sp_pkg::sp_addr_t i_adr_i,
   input  logic             i_stb_i,
   output sp_pkg::sp_word_t i_dat_o,
   output logic             i_ack_o
);

   localparam int idx_bits = $clog2(depth_words);

   sp_pkg::sp_word_t mem [depth_words];

   logic [idx_bits-1:0] d_idx;
   logic [idx_bits-1:0] i_idx;
   logic                d_go;
   logic                i_go;

   assign d_idx = d_adr_i[2 +: idx_bits];   // word index, byte offset dropped.
   assign i_idx = i_adr_i[2 +: idx_bits];

   // a strobe held through its acknowledge cycle must not start a second access.
   assign d_go = d_stb_i && !d_ack_o;
   assign i_go = i_stb_i && !i_ack_o;

   always_ff @(posedge clk) begin
      if (d_go) begin
         d_dat_o <= mem[d_idx];   // returns the word as it was before the write.
         if (d_we_i) begin
            for (int b = 0; b < 4; b++) begin
               if (d_sel_i[b]) begin
                  mem[d_idx][b*8 +: 8] <= d_dat_i[b*8 +: 8];
               end
            end
         end
      end
      if (i_go) begin
         i_dat_o <= mem[i_idx];
      end
   end

   always_ff @(posedge clk) begin
      if (rst_i) begin
         d_ack_o <= 1'b0;
         i_ack_o <= 1'b0;
      end else begin
         d_ack_o <= d_go;
         i_ack_o <= i_go;
      end
   end

   a_d_ack_single : assert property (@(posedge clk) disable iff (rst_i)
      d_ack_o |=> !d_ack_o);

endmodule

// File: hw/sp_byte_bridge.sv
`timescale 1ns/1ps

`include "sp_config.svh"

module sp_byte_bridge (
   input  logic                 clk,
   input  logic                 rst_i,
   input  sp_pkg::sp_addr_t     adr_i,
   input  sp_pkg::sp_word_t     dat_i,
   input  sp_pkg::sp_sel_t      sel_i,
   input  logic                 we_i,
   input  logic                 stb_i,
   input  logic                 cyc_i,
   output sp_pkg::sp_word_t     dat_o,
   output logic                 ack_o,
   output sp_pkg::sp_ext_addr_t wb_adr_o,
   output sp_pkg::sp_byte_t     wb_dat_o,
   output logic                 wb_sel_o,
   output logic                 wb_we_o,
   output logic                 wb_stb_o,
   output logic                 wb_cyc_o,
   input  sp_pkg::sp_byte_t     wb_dat_i,
   input  logic                 wb_ack_i
);

   sp_pkg::bridge_state_t state;
   logic [1:0]            beat_cnt;
   logic [1:0]            lane;
   sp_pkg::sp_word_t      rd_word;
   logic                  beat_end;

   // beat 0 carries the most significant byte, so the lane counts down.
   assign lane = 2'd3 - beat_cnt;

   assign beat_end = (state == sp_pkg::bridge_beat) && wb_ack_i;

   assign wb_adr_o = {adr_i[`SP_EXT_ADDR_WIDTH-1:2], beat_cnt};
   assign wb_dat_o = dat_i[{lane, 3'b000} +: 8];
   assign wb_sel_o = sel_i[lane];
   assign wb_stb_o = (state == sp_pkg::bridge_beat);
   assign wb_cyc_o = cyc_i && (state != sp_pkg::bridge_idle);
   assign wb_we_o  = we_i && wb_cyc_o;

   assign ack_o = (state == sp_pkg::bridge_done);   // one cycle after the last beat.
   assign dat_o = rd_word;

   always_ff @(posedge clk) begin
      if (rst_i) begin
         state    <= sp_pkg::bridge_idle;
         beat_cnt <= 2'd0;
      end else begin
         case (state)
            sp_pkg::bridge_idle: begin
               if (stb_i && cyc_i) begin
                  state    <= sp_pkg::bridge_beat;
                  beat_cnt <= 2'd0;
               end
            end
            sp_pkg::bridge_beat: begin
               if (wb_ack_i) begin
                  if (beat_cnt == 2'd3) begin
                     state <= sp_pkg::bridge_done;
                  end
                  beat_cnt <= beat_cnt + 2'd1;   // wraps back to 0 after beat 3.
               end
            end
            sp_pkg::bridge_done: begin
               state <= sp_pkg::bridge_idle;   // the core drops stb after its ack.
            end
            default: begin
               state <= sp_pkg::bridge_idle;
            end
         endcase
      end
   end

   // first byte read lands in the top lane after four shifts.
   always_ff @(posedge clk) begin
      if (beat_end) begin
         rd_word <= {rd_word[23:0], wb_dat_i};
      end
   end

   a_stb_in_cyc : assert property (@(posedge clk) disable iff (rst_i)
      wb_stb_o |-> wb_cyc_o);

   // the core must hold its address while a beat waits on the device.
   a_adr_stable : assert property (@(posedge clk) disable iff (rst_i)
      wb_stb_o && !wb_ack_i |=> $stable(wb_adr_o));

endmodule

// File: hw/sp_data_fabric.sv
`timescale 1ns/1ps

`include "sp_config.svh"

module sp_data_fabric (
   input  logic             clk,
   input  logic             rst_i,
   input  sp_pkg::sp_addr_t d_adr_i,
   input  logic             d_stb_i,
   input  logic             d_cyc_i,
   output logic             mem_stb_o,
   output logic             ext_stb_o,
   output logic             ext_cyc_o,
   input  logic             mem_ack_i,
   input  sp_pkg::sp_word_t mem_dat_i,
   input  logic             ext_ack_i,
   input  sp_pkg::sp_word_t ext_dat_i,
   output logic             d_ack_o,
   output logic             d_err_o,
   output sp_pkg::sp_word_t d_dat_o
);

   logic mem_hit;
   logic ext_hit;
   logic req;
   logic err_q;

   assign mem_hit = !d_adr_i[31];   // low half of the address space.
   assign ext_hit = (d_adr_i[31:24] == `SP_EXT_REGION);
   assign req     = d_stb_i && d_cyc_i;

   assign mem_stb_o = req && mem_hit;
   assign ext_stb_o = req && ext_hit;
   assign ext_cyc_o = d_cyc_i && ext_hit;

   assign d_ack_o = mem_ack_i || ext_ack_i;
   assign d_dat_o = ext_ack_i ? ext_dat_i : mem_dat_i;
   assign d_err_o = err_q;

   // unmapped strobes get a single error pulse so the core never stalls.
   always_ff @(posedge clk) begin
      if (rst_i) begin
         err_q <= 1'b0;
      end else begin
         err_q <= req && !mem_hit && !ext_hit && !err_q;
      end
   end

   a_one_target : assert property (@(posedge clk) disable iff (rst_i)
      !(mem_stb_o && ext_stb_o));

endmodule

// File: hw/sp_top.sv
`timescale 1ns/1ps

module sp_top (
   input  logic                 clk,
   input  logic                 rst_i,
   input  sp_pkg::sp_addr_t     d_adr_i,
   input  sp_pkg::sp_word_t     d_dat_i,
   input  sp_pkg::sp_sel_t      d_sel_i,
   input  logic                 d_we_i,
   input  logic                 d_stb_i,
   input  logic                 d_cyc_i,
   output sp_pkg::sp_word_t     d_dat_o,
   output logic                 d_ack_o,
   output logic                 d_err_o,
   input  sp_pkg::sp_addr_t     i_adr_i,
   input  logic                 i_stb_i,
   output sp_pkg::sp_word_t     i_dat_o,
   output logic                 i_ack_o,
   output sp_pkg::sp_ext_addr_t wb_adr_o,
   output sp_pkg::sp_byte_t     wb_dat_o,
   output logic                 wb_sel_o,
   output logic                 wb_we_o,
   output logic                 wb_stb_o,
   output logic                 wb_cyc_o,
   input  sp_pkg::sp_byte_t     wb_dat_i,
   input  logic                 wb_ack_i
);

   logic             mem_stb;
   logic             ext_stb;
   logic             ext_cyc;
   logic             mem_ack;
   logic             ext_ack;
   sp_pkg::sp_word_t mem_dat;
   sp_pkg::sp_word_t ext_dat;

   sp_data_fabric i_fabric (
      .clk       (clk),
      .rst_i     (rst_i),
      .d_adr_i   (d_adr_i),
      .d_stb_i   (d_stb_i),
      .d_cyc_i   (d_cyc_i),
      .mem_stb_o (mem_stb),
      .ext_stb_o (ext_stb),
      .ext_cyc_o (ext_cyc),
      .mem_ack_i (mem_ack),
      .mem_dat_i (mem_dat),
      .ext_ack_i (ext_ack),
      .ext_dat_i (ext_dat),
      .d_ack_o   (d_ack_o),
      .d_err_o   (d_err_o),
      .d_dat_o   (d_dat_o)
   );

   sp_local_mem i_mem (
      .clk     (clk),
      .rst_i   (rst_i),
      .d_adr_i (d_adr_i),
      .d_dat_i (d_dat_i),
      .d_sel_i (d_sel_i),
      .d_we_i  (d_we_i),
      .d_stb_i (mem_stb),
      .d_dat_o (mem_dat),
      .d_ack_o (mem_ack),
      .i_adr_i (i_adr_i),
      .i_stb_i (i_stb_i),
      .i_dat_o (i_dat_o),
      .i_ack_o (i_ack_o)
   );

   sp_byte_bridge i_bridge (
      .clk      (clk),
      .rst_i    (rst_i),
      .adr_i    (d_adr_i),
      .dat_i    (d_dat_i),
      .sel_i    (d_sel_i),
      .we_i     (d_we_i),
      .stb_i    (ext_stb),
      .cyc_i    (ext_cyc),
      .dat_o    (ext_dat),
      .ack_o    (ext_ack),
      .wb_adr_o (wb_adr_o),
      .wb_dat_o (wb_dat_o),
      .wb_sel_o (wb_sel_o),
      .wb_we_o  (wb_we_o),
      .wb_stb_o (wb_stb_o),
      .wb_cyc_o (wb_cyc_o),
      .wb_dat_i (wb_dat_i),
      .wb_ack_i (wb_ack_i)
   );

endmodule

// File: test/byte_slave_model.sv
`timescale 1ns/1ps

module byte_slave_model (
   input  logic                 clk,
   input  logic                 rst_i,
   input  sp_pkg::sp_ext_addr_t wb_adr_i,
   input  sp_pkg::sp_byte_t     wb_dat_i,
   input  logic                 wb_sel_i,
   input  logic                 wb_we_i,
   input  logic                 wb_stb_i,
   input  logic                 wb_cyc_i,
   output sp_pkg::sp_byte_t     wb_dat_o,
   output logic                 wb_ack_o
);

   sp_pkg::sp_byte_t mem [256];

   int unsigned wait_left;
   logic [7:0]  idx;

   assign idx = wb_adr_i[7:0];   // only the low byte of the address decodes.

   always @(posedge clk) begin
      if (rst_i) begin
         wb_ack_o  <= 1'b0;
         wb_dat_o  <= '0;
         wait_left <= $urandom % 4;
      end else if (wb_ack_o) begin
         wb_ack_o  <= 1'b0;
         wait_left <= $urandom % 4;   // fresh delay for the next beat.
      end else if (wb_stb_i && wb_cyc_i) begin
         if (wait_left == 0) begin
            wb_ack_o <= 1'b1;
            wb_dat_o <= mem[idx];
            if (wb_we_i && wb_sel_i) begin
               mem[idx] <= wb_dat_i;
            end
         end else begin
            wait_left <= wait_left - 1;
         end
      end
   end

endmodule

// File: test/sp_tb.sv
`timescale 1ns/1ps

module sp_tb;

   localparam int clk_period   = 40;
   localparam int reset_cycles = 16;
   localparam int num_accesses = 27;

   logic                 clk;
   logic                 rst_i;
   sp_pkg::sp_addr_t     d_adr_i;
   sp_pkg::sp_word_t     d_dat_i;
   sp_pkg::sp_sel_t      d_sel_i;
   logic                 d_we_i;
   logic                 d_stb_i;
   logic                 d_cyc_i;
   sp_pkg::sp_word_t     d_dat_o;
   logic                 d_ack_o;
   logic                 d_err_o;
   sp_pkg::sp_addr_t     i_adr_i;
   logic                 i_stb_i;
   sp_pkg::sp_word_t     i_dat_o;
   logic                 i_ack_o;
   sp_pkg::sp_ext_addr_t wb_adr_o;
   sp_pkg::sp_byte_t     wb_dat_o;
   logic                 wb_sel_o;
   logic                 wb_we_o;
   logic                 wb_stb_o;
   logic                 wb_cyc_o;
   sp_pkg::sp_byte_t     wb_dat_i;
   logic                 wb_ack_i;

   int          err_count;
   int          check_count;
   int          tests_run;
   int          tests_failed;
   int          test_err_start;
   int          ext_stb_cycles = 0;
   string       cur_test;

   sp_top i_dut (.*);

   byte_slave_model i_slave (
      .clk      (clk),
      .rst_i    (rst_i),
      .wb_adr_i (wb_adr_o),
      .wb_dat_i (wb_dat_o),
      .wb_sel_i (wb_sel_o),
      .wb_we_i  (wb_we_o),
      .wb_stb_i (wb_stb_o),
      .wb_cyc_i (wb_cyc_o),
      .wb_dat_o (wb_dat_i),
      .wb_ack_o (wb_ack_i)
   );

   initial begin
      clk = 1'b0;
      forever #(clk_period / 2) clk = ~clk;
   end

   always @(posedge clk) begin
      if (!rst_i && wb_stb_o) begin
         ext_stb_cycles <= ext_stb_cycles + 1;   // any byte bus activity at all.
      end
   end

   initial begin
      #((reset_cycles + num_accesses * 50) * clk_period);
      $display("timeout: the tests did not finish within %0d cycles",
               reset_cycles + num_accesses * 50);
      $display("Test failed");
      $finish;
   end

   task automatic check_value(input string what, input logic [31:0] expected,
                              input logic [31:0] actual);
      check_count++;
      if (actual !== expected) begin
         err_count++;
         $display("mismatch in %s, %s: expected %h, actual %h", cur_test, what, expected, actual);
      end
   endtask

   task automatic start_test(input string name);
      cur_test       = name;
      test_err_start = err_count;
   endtask

   task automatic finish_test();
      tests_run++;
      if (err_count == test_err_start) begin
         $display("test %s: ok", cur_test);
      end else begin
         tests_failed++;
         $display("test %s: %0d errors", cur_test, err_count - test_err_start);
      end
   endtask

   task automatic data_access(input sp_pkg::sp_addr_t adr, input sp_pkg::sp_word_t wdat,
                              input sp_pkg::sp_sel_t sel, input logic we,
                              output sp_pkg::sp_word_t rdat, output logic ack,
                              output logic err);
      @(negedge clk);
      d_adr_i = adr;
      d_dat_i = wdat;
      d_sel_i = sel;
      d_we_i  = we;
      d_stb_i = 1'b1;
      d_cyc_i = 1'b1;
      do begin
         @(negedge clk);
      end while (!(d_ack_o || d_err_o));
      rdat    = d_dat_o;
      ack     = d_ack_o;
      err     = d_err_o;
      d_stb_i = 1'b0;   // low across the next edge before another access.
      d_cyc_i = 1'b0;
      d_we_i  = 1'b0;
   endtask

   task automatic write_word(input sp_pkg::sp_addr_t adr, input sp_pkg::sp_word_t wdat,
                             input sp_pkg::sp_sel_t sel);
      sp_pkg::sp_word_t rdat;
      logic             ack;
      logic             err;
      data_access(adr, wdat, sel, 1'b1, rdat, ack, err);
      check_value("write ack", 2, {ack, err});
   endtask

   task automatic read_word(input sp_pkg::sp_addr_t adr, output sp_pkg::sp_word_t rdat);
      logic ack;
      logic err;
      data_access(adr, '0, 4'b1111, 1'b0, rdat, ack, err);
      check_value("read ack", 2, {ack, err});
   endtask

   task automatic fetch_word(input sp_pkg::sp_addr_t adr, output sp_pkg::sp_word_t dat);
      @(negedge clk);
      i_adr_i = adr;
      i_stb_i = 1'b1;
      do begin
         @(negedge clk);
      end while (!i_ack_o);
      dat     = i_dat_o;
      i_stb_i = 1'b0;
   endtask

   task automatic local_readback();
      sp_pkg::sp_addr_t addrs [4] = '{32'h0, 32'h4, 32'h100, 32'hffc};
      sp_pkg::sp_word_t wdata [4];
      sp_pkg::sp_word_t rdata;
      start_test("local_readback");
      foreach (wdata[n]) begin
         wdata[n] = $urandom;
         write_word(addrs[n], wdata[n], 4'b1111);
      end
      foreach (wdata[n]) begin
         read_word(addrs[n], rdata);
         check_value("read data", wdata[n], rdata);
      end
      finish_test();
   endtask

   task automatic byte_lane_write();
      sp_pkg::sp_word_t rdata;
      start_test("byte_lane_write");
      write_word(32'h200, 32'h11223344, 4'b1111);
      write_word(32'h200, 32'haabbccdd, 4'b0010);
      read_word(32'h200, rdata);
      check_value("merged word", (32'h11223344 & ~32'h0000ff00) | (32'haabbccdd & 32'h0000ff00),
                  rdata);
      finish_test();
   endtask

   task automatic instr_fetch();
      sp_pkg::sp_word_t wdata [3];
      sp_pkg::sp_word_t rdata;
      sp_pkg::sp_word_t idata;
      start_test("instr_fetch");
      foreach (wdata[n]) begin
         wdata[n] = $urandom;
         write_word(32'h300 + 4 * n, wdata[n], 4'b1111);
      end
      foreach (wdata[n]) begin
         fetch_word(32'h300 + 4 * n, idata);
         check_value("fetch data", wdata[n], idata);
      end
      fork
         fetch_word(32'h304, idata);
         read_word(32'h308, rdata);
      join
      check_value("parallel fetch", wdata[1], idata);
      check_value("parallel read", wdata[2], rdata);
      finish_test();
   endtask

   task automatic ext_write();
      sp_pkg::sp_addr_t addrs [2] = '{32'h80000010, 32'h80000040};
      sp_pkg::sp_word_t wdata;
      start_test("ext_write");
      foreach (addrs[n]) begin
         wdata = $urandom;
         write_word(addrs[n], wdata, 4'b1111);
         for (int b = 0; b < 4; b++) begin
            check_value("model byte", wdata[31 - 8 * b -: 8], i_slave.mem[addrs[n][7:0] + b]);
         end
      end
      finish_test();
   endtask

   task automatic ext_read();
      logic [7:0]       offs [4] = '{8'h20, 8'h24, 8'h80, 8'hfc};
      sp_pkg::sp_byte_t bytes [4];
      sp_pkg::sp_word_t rdata;
      start_test("ext_read");
      foreach (offs[n]) begin
         for (int b = 0; b < 4; b++) begin
            bytes[b]                  = $urandom;
            i_slave.mem[offs[n] + b] = bytes[b];
         end
         read_word({24'h800000, offs[n]}, rdata);   // first byte is the most significant.
         check_value("read word", {bytes[0], bytes[1], bytes[2], bytes[3]}, rdata);
      end
      finish_test();
   endtask

   task automatic unmapped_access();
      int               stb_before;
      sp_pkg::sp_word_t rdata;
      logic             ack;
      logic             err;
      start_test("unmapped_access");
      stb_before = ext_stb_cycles;
      data_access(32'h90000000, '0, 4'b1111, 1'b0, rdata, ack, err);
      check_value("read ack and err", 1, {ack, err});
      data_access(32'h90000000, 32'h12345678, 4'b1111, 1'b1, rdata, ack, err);
      check_value("write ack and err", 1, {ack, err});
      check_value("byte bus strobes", stb_before, ext_stb_cycles);
      finish_test();
   endtask

   initial begin
      void'($urandom(32'h14b52923));
      err_count    = 0;
      check_count  = 0;
      tests_run    = 0;
      tests_failed = 0;
      rst_i        = 1'b1;
      d_adr_i      = '0;
      d_dat_i      = '0;
      d_sel_i      = '0;
      d_we_i       = 1'b0;
      d_stb_i      = 1'b0;
      d_cyc_i      = 1'b0;
      i_adr_i      = '0;
      i_stb_i      = 1'b0;
      repeat (reset_cycles) @(negedge clk);
      rst_i = 1'b0;
      local_readback();
      byte_lane_write();
      instr_fetch();
      ext_write();
      ext_read();
      unmapped_access();
      @(negedge clk);
      $display("summary: %0d tests, %0d failed, %0d checks, %0d errors",
               tests_run, tests_failed, check_count, err_count);
      if (err_count == 0) begin
         $display("Test passed");
      end else begin
         $display("Test failed");
      end
      $finish;
   end

endmodule

// File: filelist.f
+incdir+hw
hw/sp_pkg.sv
hw/sp_local_mem.sv
hw/sp_byte_bridge.sv
hw/sp_data_fabric.sv
hw/sp_top.sv
test/byte_slave_model.sv
test/sp_tb.sv
